// File: hdl/mont_pkg.sv
package mont_pkg;

    // Defaults for the top level, overridden per instance
    parameter int DEFAULT_WIDTH = 1024;
    parameter int DEFAULT_CHUNK = 64;

    // Headroom above WIDTH for 3M + 3B growth and the sign bit
    parameter int EXT_BITS = 4;

    // Adder operand B sources
    parameter logic [1:0] SEL_B      = 2'd0;
    parameter logic [1:0] SEL_M      = 2'd1;
    parameter logic [1:0] SEL_B_MULT = 2'd2;
    parameter logic [1:0] SEL_M_MULT = 2'd3;

    typedef enum logic [3:0] {
        st_idle,
        st_pre_b,
        st_pre_m,
        st_add_b,
        st_add_m,
        st_sub_m,
        st_fix_m,
        st_done
    } mont_state_t;

    // Datapath controls, one set per cycle
    typedef struct packed {
        logic       load;
        logic [1:0] operand_sel;
        logic       acc_feed;
        logic       shift_acc;
        logic       capture_b3;
        logic       capture_m3;
        logic       capture_acc;
        logic       shift_a;
        logic       move_result;
    } mont_ctrl_t;

    // Request to the shared wide adder
    typedef struct packed {
        logic start;
        logic subtract;
    } adder_op_t;

endpackage

// File: hdl/mont_adder.sv
`timescale 1ns/1ps

module mont_adder #(
    parameter int WIDTH = mont_pkg::DEFAULT_WIDTH,
    parameter int CHUNK = mont_pkg::DEFAULT_CHUNK
) (
    input  logic                               clk,
    input  logic                               resetn,
    input  mont_pkg::adder_op_t                op,
    input  logic [WIDTH+mont_pkg::EXT_BITS-1:0] opnd_a,
    input  logic [WIDTH+mont_pkg::EXT_BITS-1:0] opnd_b,
    output logic [WIDTH+mont_pkg::EXT_BITS-1:0] sum,
    output logic                               sign,
    output logic                               add_done
);

    localparam int W      = WIDTH + mont_pkg::EXT_BITS;
    localparam int CHUNKS = (W + CHUNK - 1) / CHUNK;
    localparam int PAD_W  = CHUNKS * CHUNK;
    localparam int CNT_W  = $clog2(CHUNKS + 1);

    logic [PAD_W-1:0] pad_a;
    logic [PAD_W-1:0] pad_b;
    logic [PAD_W-1:0] a_sh;
    logic [PAD_W-1:0] b_sh;
    logic [PAD_W-1:0] sum_sh;
    logic [CHUNK-1:0] cur_a;
    logic [CHUNK-1:0] cur_b;
    logic [CHUNK-1:0] chunk_sum;
    logic             cur_cin;
    logic             carry;
    logic             carry_out;
    logic             busy;
    logic [CNT_W-1:0] cnt;

    // Subtraction as a + ~b + 1
    assign pad_a = PAD_W'(opnd_a);
    assign pad_b = op.subtract ? ~(PAD_W'(opnd_b)) : PAD_W'(opnd_b);

    // Chunk 0 comes straight from the inputs on the start cycle
    always_comb begin
        if (op.start) begin
            cur_a   = pad_a[CHUNK-1:0];
            cur_b   = pad_b[CHUNK-1:0];
            cur_cin = op.subtract;
        end else begin
            cur_a   = a_sh[CHUNK-1:0];
            cur_b   = b_sh[CHUNK-1:0];
            cur_cin = carry;
        end
    end

    assign {carry_out, chunk_sum} = {1'b0, cur_a} + {1'b0, cur_b} + (CHUNK + 1)'(cur_cin);

    always_ff @(posedge clk) begin
        if (op.start) begin
            a_sh <= pad_a >> CHUNK;
            b_sh <= pad_b >> CHUNK;
        end else if (busy) begin
            a_sh <= a_sh >> CHUNK;
            b_sh <= b_sh >> CHUNK;
        end
        // Partial sums enter at the top and settle in place after the last chunk
        if (op.start || busy) begin
            sum_sh <= (sum_sh >> CHUNK) | (PAD_W'(chunk_sum) << (PAD_W - CHUNK));
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            carry    <= 1'b0;
            cnt      <= '0;
            add_done <= 1'b0;
        end else begin
            add_done <= 1'b0;
            if (op.start) begin
                carry    <= carry_out;
                cnt      <= CNT_W'(1);
                busy     <= (CHUNKS > 1);
                add_done <= (CHUNKS == 1);
            end else if (busy) begin
                carry <= carry_out;
                cnt   <= cnt + 1'b1;
                if (cnt == CNT_W'(CHUNKS - 1)) begin
                    busy     <= 1'b0;
                    add_done <= 1'b1;
                end
            end
        end
    end

    assign sum  = sum_sh[W-1:0];
    assign sign = sum_sh[W-1];

endmodule

// File: hdl/mont_multiple_select.sv
`timescale 1ns/1ps

module mont_multiple_select #(
    parameter int WIDTH = mont_pkg::DEFAULT_WIDTH
) (
    input  logic [1:0]                          a_digit,
    input  logic [1:0]                          acc_low,
    input  logic                                m_bit1,
    input  logic [WIDTH-1:0]                    b,
    input  logic [WIDTH-1:0]                    m,
    input  logic [WIDTH+1:0]                    b3,
    input  logic [WIDTH+1:0]                    m3,
    output logic [WIDTH+mont_pkg::EXT_BITS-1:0] b_multiple,
    output logic [WIDTH+mont_pkg::EXT_BITS-1:0] m_multiple
);

    localparam int OUT_W = WIDTH + mont_pkg::EXT_BITS;

    logic [1:0] q_digit;

    // Digit times x, with 3x taken from the precomputed register
    function automatic logic [OUT_W-1:0] pick(
        input logic [1:0]       digit,
        input logic [WIDTH-1:0] x,
        input logic [WIDTH+1:0] x3
    );
        case (digit)
            2'd0:    pick = '0;
            2'd1:    pick = OUT_W'(x);
            2'd2:    pick = OUT_W'({x, 1'b0});
            default: pick = OUT_W'(x3);
        endcase
    endfunction

    // q chosen so that acc + q*m is divisible by 4
    // m = 1 mod 4 needs q = -c, m = 3 mod 4 needs q = c
    assign q_digit = m_bit1 ? acc_low : (2'd0 - acc_low);

    assign b_multiple = pick(a_digit, b, b3);
    assign m_multiple = pick(q_digit, m, m3);

endmodule

// File: hdl/mont_datapath.sv
`timescale 1ns/1ps

module mont_datapath #(
    parameter int WIDTH = mont_pkg::DEFAULT_WIDTH
) (
    input  logic                                clk,
    input  logic                                resetn,
    input  mont_pkg::mont_ctrl_t                ctrl,
    input  logic [WIDTH-1:0]                    in_a,
    input  logic [WIDTH-1:0]                    in_b,
    input  logic [WIDTH-1:0]                    in_m,
    input  logic [WIDTH+mont_pkg::EXT_BITS-1:0] sum,
    output logic [WIDTH+mont_pkg::EXT_BITS-1:0] opnd_a,
    output logic [WIDTH+mont_pkg::EXT_BITS-1:0] opnd_b,
    output logic                                acc_sign,
    output logic [WIDTH-1:0]                    result
);

    localparam int ACC_W = WIDTH + mont_pkg::EXT_BITS;

    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [WIDTH-1:0] m;
    logic [WIDTH+1:0] b3;
    logic [WIDTH+1:0] m3;
    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] b_multiple;
    logic [ACC_W-1:0] m_multiple;

    // Operands; a is consumed one radix-4 digit per iteration
    always_ff @(posedge clk) begin
        if (!resetn) begin
            a <= '0;
            b <= '0;
            m <= '0;
        end else if (ctrl.load) begin
            a <= in_a;
            b <= in_b;
            m <= in_m;
        end else if (ctrl.shift_a) begin
            a <= {2'b00, a[WIDTH-1:2]};
        end
    end

    // 3B and 3M, built up over three additions each
    always_ff @(posedge clk) begin
        if (!resetn) begin
            b3 <= '0;
            m3 <= '0;
        end else begin
            if (ctrl.capture_b3) begin
                b3 <= sum[WIDTH+1:0];
            end
            if (ctrl.capture_m3) begin
                m3 <= sum[WIDTH+1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc <= '0;
        end else if (ctrl.capture_acc) begin
            // Divide by 4 after the m step; low two bits are zero there
            acc <= ctrl.shift_acc ? {2'b00, sum[ACC_W-1:2]} : sum;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result <= '0;
        end else if (ctrl.move_result) begin
            result <= acc[WIDTH-1:0];
        end
    end

    mont_multiple_select #(
        .WIDTH (WIDTH)
    ) select_inst (
        .a_digit    (a[1:0]),
        .acc_low    (acc[1:0]),
        .m_bit1     (m[1]),
        .b          (b),
        .m          (m),
        .b3         (b3),
        .m3         (m3),
        .b_multiple (b_multiple),
        .m_multiple (m_multiple)
    );

    assign opnd_a = ctrl.acc_feed ? acc : '0;

    always_comb begin
        case (ctrl.operand_sel)
            mont_pkg::SEL_B:      opnd_b = ACC_W'(b);
            mont_pkg::SEL_M:      opnd_b = ACC_W'(m);
            mont_pkg::SEL_B_MULT: opnd_b = b_multiple;
            default:              opnd_b = m_multiple;
        endcase
    end

    assign acc_sign = acc[ACC_W-1];

endmodule

// File: hdl/mont_ctrl.sv
`timescale 1ns/1ps

module mont_ctrl #(
    parameter int WIDTH = mont_pkg::DEFAULT_WIDTH
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 start,
    input  logic                 add_done,
    input  logic                 acc_sign,
    output mont_pkg::mont_ctrl_t ctrl,
    output mont_pkg::adder_op_t  op,
    output logic                 done
);

    localparam int DIGITS  = WIDTH / 2;
    localparam int DIGIT_W = $clog2(DIGITS);

    mont_pkg::mont_state_t state;
    mont_pkg::mont_state_t state_nxt;

    logic               launched;
    logic [1:0]         step_cnt;
    logic [DIGIT_W-1:0] digit_cnt;
    logic               step_last;
    logic               digit_last;
    logic               adding;
    logic               sub_finished;

    assign step_last  = (step_cnt == 2'd2);
    assign digit_last = (digit_cnt == DIGIT_W'(DIGITS - 1));

    // States that use the adder once per visit
    assign adding = (state == mont_pkg::st_pre_b) || (state == mont_pkg::st_pre_m) ||
                    (state == mont_pkg::st_add_b) || (state == mont_pkg::st_add_m) ||
                    (state == mont_pkg::st_sub_m) || (state == mont_pkg::st_fix_m);

    // Last subtraction went negative, time to add m back
    assign sub_finished = (state == mont_pkg::st_sub_m) && !launched && acc_sign;

    always_comb begin
        state_nxt   = state;
        ctrl        = '0;
        op          = '0;
        op.start    = adding && !launched && !sub_finished;
        case (state)
            mont_pkg::st_idle: begin
                if (start) begin
                    ctrl.load = 1'b1;
                    state_nxt = mont_pkg::st_pre_b;
                end
            end
            mont_pkg::st_pre_b: begin
                ctrl.operand_sel = mont_pkg::SEL_B;
                ctrl.acc_feed    = (step_cnt != 2'd0);
                if (add_done) begin
                    ctrl.capture_b3  = 1'b1;
                    ctrl.capture_acc = 1'b1;
                    if (step_last) begin
                        state_nxt = mont_pkg::st_pre_m;
                    end
                end
            end
            mont_pkg::st_pre_m: begin
                ctrl.operand_sel = mont_pkg::SEL_M;
                ctrl.acc_feed    = (step_cnt != 2'd0);
                if (add_done) begin
                    ctrl.capture_m3  = 1'b1;
                    ctrl.capture_acc = 1'b1;
                    if (step_last) begin
                        state_nxt = mont_pkg::st_add_b;
                    end
                end
            end
            mont_pkg::st_add_b: begin
                ctrl.operand_sel = mont_pkg::SEL_B_MULT;
                // Accumulator still holds 3M on the first digit
                ctrl.acc_feed    = (digit_cnt != '0);
                if (add_done) begin
                    ctrl.capture_acc = 1'b1;
                    ctrl.shift_a     = 1'b1;
                    state_nxt        = mont_pkg::st_add_m;
                end
            end
            mont_pkg::st_add_m: begin
                ctrl.operand_sel = mont_pkg::SEL_M_MULT;
                ctrl.acc_feed    = 1'b1;
                if (add_done) begin
                    ctrl.capture_acc = 1'b1;
                    ctrl.shift_acc   = 1'b1;
                    state_nxt = digit_last ? mont_pkg::st_sub_m : mont_pkg::st_add_b;
                end
            end
            mont_pkg::st_sub_m: begin
                ctrl.operand_sel = mont_pkg::SEL_M;
                ctrl.acc_feed    = 1'b1;
                op.subtract      = 1'b1;
                if (sub_finished) begin
                    state_nxt = mont_pkg::st_fix_m;
                end else if (add_done) begin
                    ctrl.capture_acc = 1'b1;
                end
            end
            mont_pkg::st_fix_m: begin
                ctrl.operand_sel = mont_pkg::SEL_M;
                ctrl.acc_feed    = 1'b1;
                if (add_done) begin
                    ctrl.capture_acc = 1'b1;
                    state_nxt        = mont_pkg::st_done;
                end
            end
            mont_pkg::st_done: begin
                ctrl.move_result = 1'b1;
                state_nxt        = mont_pkg::st_idle;
            end
            default: begin
                state_nxt = mont_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= mont_pkg::st_idle;
            launched  <= 1'b0;
            step_cnt  <= 2'd0;
            digit_cnt <= '0;
            done      <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= (state == mont_pkg::st_done);
            if (op.start) begin
                launched <= 1'b1;
            end else if (add_done) begin
                launched <= 1'b0;
            end
            if (ctrl.load) begin
                step_cnt  <= 2'd0;
                digit_cnt <= '0;
            end else if (add_done) begin
                if (state == mont_pkg::st_pre_b || state == mont_pkg::st_pre_m) begin
                    step_cnt <= step_last ? 2'd0 : step_cnt + 2'd1;
                end
                if (state == mont_pkg::st_add_m) begin
                    digit_cnt <= digit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/montgomery.sv
`timescale 1ns/1ps

module montgomery #(
    parameter int WIDTH = mont_pkg::DEFAULT_WIDTH,
    parameter int CHUNK = mont_pkg::DEFAULT_CHUNK
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  logic [WIDTH-1:0] in_a,
    input  logic [WIDTH-1:0] in_b,
    input  logic [WIDTH-1:0] in_m,
    output logic [WIDTH-1:0] result,
    output logic             done
);

    mont_pkg::mont_ctrl_t ctrl;
    mont_pkg::adder_op_t  op;

    logic [WIDTH+mont_pkg::EXT_BITS-1:0] opnd_a;
    logic [WIDTH+mont_pkg::EXT_BITS-1:0] opnd_b;
    logic [WIDTH+mont_pkg::EXT_BITS-1:0] sum;
    logic                                add_done;
    logic                                acc_sign;

    mont_ctrl #(
        .WIDTH (WIDTH)
    ) ctrl_inst (
        .clk      (clk),
        .resetn   (resetn),
        .start    (start),
        .add_done (add_done),
        .acc_sign (acc_sign),
        .ctrl     (ctrl),
        .op       (op),
        .done     (done)
    );

    mont_datapath #(
        .WIDTH (WIDTH)
    ) datapath_inst (
        .clk      (clk),
        .resetn   (resetn),
        .ctrl     (ctrl),
        .in_a     (in_a),
        .in_b     (in_b),
        .in_m     (in_m),
        .sum      (sum),
        .opnd_a   (opnd_a),
        .opnd_b   (opnd_b),
        .acc_sign (acc_sign),
        .result   (result)
    );

    // Sign is read back from the stored accumulator instead
    mont_adder #(
        .WIDTH (WIDTH),
        .CHUNK (CHUNK)
    ) adder_inst (
        .clk      (clk),
        .resetn   (resetn),
        .op       (op),
        .opnd_a   (opnd_a),
        .opnd_b   (opnd_b),
        .sum      (sum),
        .sign     (),
        .add_done (add_done)
    );

endmodule

// File: test/montgomery_checker.sv
`timescale 1ns/1ps

module montgomery_checker #(
    parameter int WIDTH  = 64,
    parameter int NAME_W = 96
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  logic [WIDTH-1:0]  in_a,
    input  logic [WIDTH-1:0]  in_b,
    input  logic [WIDTH-1:0]  in_m,
    input  logic [NAME_W-1:0] test_name,
    input  logic [WIDTH-1:0]  exp_value,
    input  logic              exp_known,
    input  logic              done,
    input  logic [WIDTH-1:0]  result,
    output int                pass_count,
    output int                fail_count,
    output int                error_count,
    output int                done_count
);

    logic              busy;
    logic              done_prev;
    logic [WIDTH-1:0]  held;
    logic [WIDTH-1:0]  expected;
    logic [NAME_W-1:0] name;

    // Bit-serial Montgomery product a*b*2^-WIDTH mod m
    function automatic logic [WIDTH-1:0] mont_model(
        input logic [WIDTH-1:0] a,
        input logic [WIDTH-1:0] b,
        input logic [WIDTH-1:0] m
    );
        logic [WIDTH+1:0] c;
        c = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (a[i]) begin
                c = c + {2'b00, b};
            end
            if (c[0]) begin
                c = c + {2'b00, m};
            end
            c = c >> 1;
        end
        // Loop leaves c below 2m
        while (c >= {2'b00, m}) begin
            c = c - {2'b00, m};
        end
        return c[WIDTH-1:0];
    endfunction

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!resetn) begin
            busy        = 1'b0;
            done_prev   = 1'b0;
            held        = '0;
            expected    = '0;
            name        = '0;
            pass_count  = 0;
            fail_count  = 0;
            error_count = 0;
            done_count  = 0;
        end else begin
            if (done && done_prev) begin
                $display("Error: done stayed high for more than one cycle");
                error_count++;
            end
            if (done) begin
                done_count++;
                if (!busy) begin
                    $display("Error: done pulse with no operation in progress");
                    error_count++;
                end else if (result !== expected) begin
                    $display("Mismatch in test %0s: expected %h, actual %h",
                             name, expected, result);
                    fail_count++;
                end else begin
                    $display("Test %0s passed with result %h", name, result);
                    pass_count++;
                end
                busy = 1'b0;
                held = result;
            end else if (result !== held) begin
                $display("Error: result changed from %h to %h without a done pulse",
                         held, result);
                error_count++;
                held = result;
            end
            // Only an idle multiplier takes new operands
            if (start && !busy) begin
                busy     = 1'b1;
                name     = test_name;
                expected = exp_known ? exp_value : mont_model(in_a, in_b, in_m);
            end
            done_prev = done;
        end
    end

endmodule

// File: test/montgomery_tb.sv
`timescale 1ns/1ps

module montgomery_tb;

    localparam int WIDTH        = 64;
    localparam int CHUNK        = 16;
    localparam int NAME_W       = 96;
    localparam int N_FIXED      = 4;
    localparam int N_RANDOM     = 8;
    localparam int N_TESTS      = N_FIXED + N_RANDOM;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 8;
    localparam int CHUNKS       = (WIDTH + mont_pkg::EXT_BITS + CHUNK - 1) / CHUNK;
    localparam int TEST_CYCLES  = (6 + WIDTH + 4) * (CHUNKS + 2);
    localparam int LIMIT_CYCLES = N_TESTS * TEST_CYCLES + RESET_CYCLES + IDLE_CYCLES;

    // Prime 2^64 - 59 leaves 59 as 2^64 mod m
    localparam logic [WIDTH-1:0] M_PRIME = 64'hffff_ffff_ffff_ffc5;

    typedef struct packed {
        logic [NAME_W-1:0] name;
        logic [WIDTH-1:0]  a;
        logic [WIDTH-1:0]  b;
        logic [WIDTH-1:0]  m;
        logic [WIDTH-1:0]  expected;
        logic              exp_known;
        logic              restart;
    } test_row_t;

    logic              clk;
    logic              resetn;
    logic              start;
    logic [WIDTH-1:0]  in_a;
    logic [WIDTH-1:0]  in_b;
    logic [WIDTH-1:0]  in_m;
    logic [WIDTH-1:0]  result;
    logic              done;
    logic [NAME_W-1:0] cur_name;
    logic [WIDTH-1:0]  cur_exp;
    logic              cur_known;
    logic [31:0]       lfsr_state;
    int                pass_count;
    int                fail_count;
    int                error_count;
    int                done_count;
    test_row_t         table_rows [N_TESTS];

    always #50 clk = ~clk;

    montgomery #(
        .WIDTH (WIDTH),
        .CHUNK (CHUNK)
    ) montgomery_inst (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .in_a   (in_a),
        .in_b   (in_b),
        .in_m   (in_m),
        .result (result),
        .done   (done)
    );

    montgomery_checker #(
        .WIDTH  (WIDTH),
        .NAME_W (NAME_W)
    ) checker_inst (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .in_a        (in_a),
        .in_b        (in_b),
        .in_m        (in_m),
        .test_name   (cur_name),
        .exp_value   (cur_exp),
        .exp_known   (cur_known),
        .done        (done),
        .result      (result),
        .pass_count  (pass_count),
        .fail_count  (fail_count),
        .error_count (error_count),
        .done_count  (done_count)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output logic [WIDTH-1:0] value);
        value = '0;
        for (int i = 0; i < WIDTH; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    function automatic test_row_t make_row(
        input logic [NAME_W-1:0] name,
        input logic [WIDTH-1:0]  a,
        input logic [WIDTH-1:0]  b,
        input logic [WIDTH-1:0]  m,
        input logic [WIDTH-1:0]  expected,
        input logic              exp_known,
        input logic              restart
    );
        return '{name, a, b, m, expected, exp_known, restart};
    endfunction

    task automatic fill_table();
        logic [WIDTH-1:0] ra;
        logic [WIDTH-1:0] rb;
        logic [WIDTH-1:0] rm;
        lfsr_state    = 32'h0000_96fe;
        table_rows[0] = make_row(NAME_W'("zero_a"), '0, 64'h0123_4567_89ab_cdef,
                                 M_PRIME, '0, 1'b1, 1'b0);
        // b is 2^WIDTH mod m so the product is 1
        table_rows[1] = make_row(NAME_W'("one_times_r"), 64'h1, 64'h3b,
                                 M_PRIME, 64'h1, 1'b1, 1'b0);
        table_rows[2] = make_row(NAME_W'("m_all_ones"), 64'hfedc_ba98_7654_3210,
                                 64'h0f1e_2d3c_4b5a_6978, '1, '0, 1'b0, 1'b0);
        table_rows[3] = make_row(NAME_W'("busy_restart"), 64'h1357_9bdf_0246_8ace,
                                 64'h2468_ace0_1357_9bdf, M_PRIME, '0, 1'b0, 1'b1);
        for (int i = 0; i < N_RANDOM; i++) begin
            random_word(rm);
            rm[0] = 1'b1;
            random_word(ra);
            random_word(rb);
            table_rows[N_FIXED + i] = make_row(NAME_W'({"random_", 8'(8'h30 + i)}),
                                               ra % rm, rb % rm, rm, '0, 1'b0, 1'b0);
        end
    endtask

    task automatic run_test(input test_row_t row);
        @(posedge clk);
        start     <= 1'b1;
        in_a      <= row.a;
        in_b      <= row.b;
        in_m      <= row.m;
        cur_name  <= row.name;
        cur_exp   <= row.expected;
        cur_known <= row.exp_known;
        @(posedge clk);
        start <= 1'b0;
        if (row.restart) begin
            // Second request mid-operation must be dropped
            repeat (5) @(posedge clk);
            start <= 1'b1;
            in_a  <= '0;
            in_b  <= '0;
            @(posedge clk);
            start <= 1'b0;
        end
        @(negedge clk);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    initial begin
        clk       = 1'b0;
        resetn    = 1'b0;
        start     = 1'b0;
        in_a      = '0;
        in_b      = '0;
        in_m      = '0;
        cur_name  = '0;
        cur_exp   = '0;
        cur_known = 1'b0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        // Quiet window after reset with no operation
        repeat (3) @(posedge clk);
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(table_rows[t]);
        end
        repeat (4) @(posedge clk);
        if (done_count != N_TESTS) begin
            $display("Expected %0d done pulses but counted %0d", N_TESTS, done_count);
        end
        $display("Tests: %0d, passed: %0d, failed: %0d, other errors: %0d, done pulses: %0d",
                 N_TESTS, pass_count, fail_count, error_count, done_count);
        if (fail_count == 0 && error_count == 0 && pass_count == N_TESTS &&
            done_count == N_TESTS) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: montgomery.f
hdl/mont_pkg.sv
hdl/mont_adder.sv
hdl/mont_multiple_select.sv
hdl/mont_datapath.sv
hdl/mont_ctrl.sv
hdl/montgomery.sv
test/montgomery_checker.sv
test/montgomery_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the Montgomery multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module montgomery_tb -Mdir obj_dir -f montgomery.f \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vmontgomery_tb > sim.log 2>&1 || true
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL: no verdict in log"; exit 1; }
echo "PASS"
